//--- hdl/peri_bus_pkg.sv
/*
 * Peripheral bus definitions
 * Request struct, size-coded strobes and the address field layout
 * shared by the decode, the GPIO block and the top level.
 */
package peri_bus_pkg;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 32;

    // Size-coded strobe, active low style: 11 is idle
    typedef logic [1:0] size_n_t;

    localparam size_n_t SIZE_BYTE = 2'b00;
    localparam size_n_t SIZE_HALF = 2'b01;
    localparam size_n_t SIZE_WORD = 2'b10;
    localparam size_n_t SIZE_IDLE = 2'b11;

    // Address bit 10 picks the simple region
    localparam int REGION_BIT = 10;

    // Slot index position within each region
    localparam int USER_SLOT_LSB   = 6;
    localparam int SIMPLE_SLOT_LSB = 4;

    // Register offset width inside one slot
    localparam int USER_OFS_W   = 6;
    localparam int SIMPLE_OFS_W = 4;

    // One bus request from the core
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        size_n_t           write_n;
        size_n_t           read_n;
    } bus_req_t;

endpackage

//--- hdl/peri_map_pkg.sv
/*
 * Peripheral map definitions
 * Slot numbering, GPIO register offsets and the per-pin
 * output function select.
 */
package peri_map_pkg;

    localparam int NUM_SLOTS = 16;
    localparam int SLOT_W    = 4;

    // User slot that holds the GPIO block
    localparam logic [SLOT_W-1:0] SLOT_GPIO = 4'd1;

    // GPIO register offsets within its slot
    localparam logic [5:0] GPIO_OUT_OFS = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS  = 6'h04;

    localparam int PIN_COUNT = 8;

    // Source of one output pin
    typedef struct packed {
        logic              simple;
        logic [SLOT_W-1:0] slot;
    } pin_sel_t;

    // Every pin starts on the GPIO output register
    localparam pin_sel_t PIN_SEL_RESET = '{simple: 1'b0, slot: SLOT_GPIO};

endpackage

//--- hdl/peri_addr_decode.sv
/*
 * Peripheral address decode
 * Splits the bus address into user and simple regions, raises the
 * write strobe of the addressed slot and selects its read data.
 * Unmapped slots read zero.
 */
`timescale 1ns/10ps

module peri_addr_decode
    import peri_bus_pkg::*;
    import peri_map_pkg::*;
#(
    parameter int NUM_SIMPLE = 2
) (
    input  bus_req_t                   i_req,
    input  logic [DATA_W-1:0]          i_gpio_rdata,
    input  logic [NUM_SIMPLE-1:0][7:0] i_bank_rdata,
    output logic                       o_gpio_wr,
    output logic [NUM_SIMPLE-1:0]      o_bank_wr,
    output logic [DATA_W-1:0]          o_rdata
);

    logic                  is_simple;
    logic                  wr_req;
    logic [SLOT_W-1:0]     user_slot;
    logic [SLOT_W-1:0]     simple_slot;
    logic [NUM_SLOTS-1:0]  user_sel;
    logic [NUM_SLOTS-1:0]  simple_sel;

    assign is_simple   = i_req.addr[REGION_BIT];
    assign wr_req      = (i_req.write_n != SIZE_IDLE);
    assign user_slot   = i_req.addr[USER_SLOT_LSB +: SLOT_W];
    assign simple_slot = i_req.addr[SIMPLE_SLOT_LSB +: SLOT_W];

    // One-hot slot select per region
    always_comb begin
        user_sel   = '0;
        simple_sel = '0;
        if (is_simple) begin
            simple_sel[simple_slot] = 1'b1;
        end else begin
            user_sel[user_slot] = 1'b1;
        end
    end

    assign o_gpio_wr = wr_req & user_sel[SLOT_GPIO];

    for (genvar b = 0; b < NUM_SIMPLE; b++) begin : g_bank_wr
        assign o_bank_wr[b] = wr_req & simple_sel[b];
    end

    // Read data of the addressed slot, banks are zero-extended
    always_comb begin
        o_rdata = '0;
        if (user_sel[SLOT_GPIO]) begin
            o_rdata = i_gpio_rdata;
        end
        for (int b = 0; b < NUM_SIMPLE; b++) begin
            if (simple_sel[b]) begin
                o_rdata = {{(DATA_W-8){1'b0}}, i_bank_rdata[b]};
            end
        end
    end

endmodule

//--- hdl/read_return.sv
/*
 * Registered read return
 * Captures the read data of the addressed slot and holds it until
 * the core signals read complete. Read-ready follows the request
 * by one cycle.
 */
`timescale 1ns/10ps

module read_return
    import peri_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_read_req,
    input  logic [DATA_W-1:0] i_rdata,
    input  logic              i_read_complete,
    output logic [DATA_W-1:0] o_data_out,
    output logic              o_read_ready
);

    logic [DATA_W-1:0] data_r;
    logic              data_hold;
    logic              capture;

    // Only a fresh read loads the register, a held value wins
    assign capture = i_read_req & ~data_hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold    <= 1'b0;
            o_read_ready <= 1'b0;
        end else begin
            if (i_read_complete) begin
                data_hold <= 1'b0;
            end
            if (capture) begin
                data_hold <= 1'b1;
            end
            o_read_ready <= i_read_req;
        end
    end

    // Payload register
    always_ff @(posedge clk) begin
        if (capture) begin
            data_r <= i_rdata;
        end
    end

    assign o_data_out = data_r;

endmodule

//--- hdl/gpio_regs.sv
/*
 * GPIO peripheral
 * Output register, input readback and one output function select
 * per pin. The selects choose which slot drives each output pin.
 */
`timescale 1ns/10ps

module gpio_regs
    import peri_bus_pkg::*;
    import peri_map_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           i_wr,
    input  bus_req_t                       i_req,
    input  logic [7:0]                     i_ui_in,
    output logic [DATA_W-1:0]              o_rdata,
    output logic [7:0]                     o_gpio_out,
    output pin_sel_t [PIN_COUNT-1:0]       o_pin_sel
);

    localparam int SEL_W = $bits(pin_sel_t);

    logic [USER_OFS_W-1:0] ofs;
    logic                  sel_hit;
    logic [2:0]            sel_idx;

    assign ofs = i_req.addr[USER_OFS_W-1:0];

    // Function selects live at bit 5 set, word aligned, pin in bits 4:2
    assign sel_hit = ofs[5] & (ofs[1:0] == 2'b00);
    assign sel_idx = ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
        end else if (i_wr && ofs == GPIO_OUT_OFS) begin
            o_gpio_out <= i_req.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < PIN_COUNT; p++) begin
                o_pin_sel[p] <= PIN_SEL_RESET;
            end
        end else if (i_wr && sel_hit) begin
            o_pin_sel[sel_idx] <= pin_sel_t'(i_req.wdata[SEL_W-1:0]);
        end
    end

    // Readback by offset, anything else reads zero
    always_comb begin
        o_rdata = '0;
        if (ofs == GPIO_OUT_OFS) begin
            o_rdata = {{(DATA_W-8){1'b0}}, o_gpio_out};
        end else if (ofs == GPIO_IN_OFS) begin
            o_rdata = {{(DATA_W-8){1'b0}}, i_ui_in};
        end else if (sel_hit) begin
            o_rdata = {{(DATA_W-SEL_W){1'b0}}, o_pin_sel[sel_idx]};
        end
    end

endmodule

//--- hdl/pin_func_mux.sv
/*
 * Output pin multiplexer
 * Each pin takes its bit from the user or simple slot named by its
 * function select. Empty slots give zero.
 */
`timescale 1ns/10ps

module pin_func_mux
    import peri_map_pkg::*;
#(
    parameter int NUM_SIMPLE = 2
) (
    input  pin_sel_t [PIN_COUNT-1:0]   i_pin_sel,
    input  logic [7:0]                 i_gpio_out,
    input  logic [NUM_SIMPLE-1:0][7:0] i_bank_out,
    output logic [PIN_COUNT-1:0]       o_uo_out
);

    logic [NUM_SLOTS-1:0][PIN_COUNT-1:0] user_src;
    logic [NUM_SLOTS-1:0][PIN_COUNT-1:0] simple_src;

    // Per-slot pin bytes, only mapped slots are non-zero
    always_comb begin
        user_src            = '0;
        simple_src          = '0;
        user_src[SLOT_GPIO] = i_gpio_out;
        for (int b = 0; b < NUM_SIMPLE; b++) begin
            simple_src[b] = i_bank_out[b];
        end
    end

    always_comb begin
        for (int p = 0; p < PIN_COUNT; p++) begin
            if (i_pin_sel[p].simple) begin
                o_uo_out[p] = simple_src[i_pin_sel[p].slot][p];
            end else begin
                o_uo_out[p] = user_src[i_pin_sel[p].slot][p];
            end
        end
    end

endmodule

//--- hdl/byte_reg_bank.sv
/*
 * Byte-interface register bank
 * Four byte registers at offsets 0 to 3 of a simple slot.
 * Register 0 drives the bank's pin outputs.
 */
`timescale 1ns/10ps

module byte_reg_bank (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_wr,
    input  logic [3:0] i_addr,
    input  logic [7:0] i_wdata,
    output logic [7:0] o_rdata,
    output logic [7:0] o_uo_out
);

    logic [3:0][7:0] regs;
    logic            in_range;

    // Offsets 4 to 15 are unmapped
    assign in_range = (i_addr[3:2] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (i_wr && in_range) begin
            regs[i_addr[1:0]] <= i_wdata;
        end
    end

    assign o_rdata  = in_range ? regs[i_addr[1:0]] : 8'h00;
    assign o_uo_out = regs[0];

endmodule

//--- hdl/peri_bus_top.sv
/*
 * Peripheral bus top level
 * Decodes core requests to the GPIO and the byte register banks,
 * returns read data through a holding register and routes the
 * selected slot outputs to the output pins.
 */
`timescale 1ns/10ps

module peri_bus_top
    import peri_bus_pkg::*;
    import peri_map_pkg::*;
#(
    parameter int NUM_SIMPLE = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [7:0]        i_ui_in,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [DATA_W-1:0] i_data,
    input  size_n_t           i_write_n,
    input  size_n_t           i_read_n,
    input  logic              i_read_complete,
    output logic [DATA_W-1:0] o_data_out,
    output logic              o_data_ready,
    output logic [7:0]        o_uo_out
);

    bus_req_t                   req;
    logic                       read_req;
    logic                       read_ready;
    logic                       gpio_wr;
    logic [NUM_SIMPLE-1:0]      bank_wr;
    logic [DATA_W-1:0]          peri_rdata;
    logic [DATA_W-1:0]          gpio_rdata;
    logic [7:0]                 gpio_out;
    pin_sel_t [PIN_COUNT-1:0]   pin_sel;
    logic [NUM_SIMPLE-1:0][7:0] bank_rdata;
    logic [NUM_SIMPLE-1:0][7:0] bank_out;

    assign req = '{addr: i_addr, wdata: i_data, write_n: i_write_n, read_n: i_read_n};

    assign read_req = (req.read_n != SIZE_IDLE);

    // Writes complete in the same cycle, reads one cycle later
    assign o_data_ready = read_ready | (req.write_n != SIZE_IDLE);

    peri_addr_decode #(
        .NUM_SIMPLE (NUM_SIMPLE)
    ) u_decode (
        .i_req        (req),
        .i_gpio_rdata (gpio_rdata),
        .i_bank_rdata (bank_rdata),
        .o_gpio_wr    (gpio_wr),
        .o_bank_wr    (bank_wr),
        .o_rdata      (peri_rdata)
    );

    read_return u_read_return (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_req      (read_req),
        .i_rdata         (peri_rdata),
        .i_read_complete (i_read_complete),
        .o_data_out      (o_data_out),
        .o_read_ready    (read_ready)
    );

    gpio_regs u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wr       (gpio_wr),
        .i_req      (req),
        .i_ui_in    (i_ui_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (gpio_out),
        .o_pin_sel  (pin_sel)
    );

    for (genvar b = 0; b < NUM_SIMPLE; b++) begin : g_bank
        byte_reg_bank u_bank (
            .clk      (clk),
            .rst_n    (rst_n),
            .i_wr     (bank_wr[b]),
            .i_addr   (req.addr[SIMPLE_OFS_W-1:0]),
            .i_wdata  (req.wdata[7:0]),
            .o_rdata  (bank_rdata[b]),
            .o_uo_out (bank_out[b])
        );
    end

    pin_func_mux #(
        .NUM_SIMPLE (NUM_SIMPLE)
    ) u_pin_mux (
        .i_pin_sel  (pin_sel),
        .i_gpio_out (gpio_out),
        .i_bank_out (bank_out),
        .o_uo_out   (o_uo_out)
    );

endmodule

//--- sim/peri_bus_checker.sv
/*
 * Read-return timing checker
 * Bound to read_return. Checks data hold, read-ready latency
 * and hold release.
 */
`timescale 1ns/10ps

module peri_bus_checker
    import peri_bus_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              i_read_req,
    input logic              i_read_complete,
    input logic [DATA_W-1:0] i_data_out,
    input logic              i_read_ready,
    input logic              i_data_hold
);

    int fail_count = 0;

    // Held data only changes after read complete
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (i_data_hold && !i_read_complete) |=> $stable(i_data_out))
    else begin
        fail_count++;
        $error("read data changed while held");
    end

    // A read leaves ready and the hold flag set in the next cycle
    a_ready_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (i_read_req && !i_read_complete) |=> (i_read_ready && i_data_hold))
    else begin
        fail_count++;
        $error("read-ready or hold flag missing one cycle after a read request");
    end

    a_hold_release: assert property (@(posedge clk) disable iff (!rst_n)
        (i_read_complete && !i_read_req) |=> !i_data_hold)
    else begin
        fail_count++;
        $error("hold flag still set after read complete");
    end

endmodule

//--- sim/tb_peri_bus.sv
/*
 * Testbench for the peripheral bus block
 * Random reads and writes to the GPIO, pin selects and byte banks,
 * checked against a register model, plus held-read and pin routing tests.
 */
`timescale 1ns/10ps

module tb_peri_bus
    import peri_bus_pkg::*;
    import peri_map_pkg::*;
;

    localparam int NUM_RAND  = 240;
    localparam int NUM_ROUTE = 64;
    localparam int NUM_OPS   = NUM_RAND + NUM_ROUTE + PIN_COUNT + 5;

    logic              clk;
    logic              rst_n;
    logic [7:0]        i_ui_in;
    logic [ADDR_W-1:0] i_addr;
    logic [DATA_W-1:0] i_data;
    size_n_t           i_write_n;
    size_n_t           i_read_n;
    logic              i_read_complete;
    logic [DATA_W-1:0] o_data_out;
    logic              o_data_ready;
    logic [7:0]        o_uo_out;

    int          seed;
    int          errors;
    int          checks;
    int          assert_fails;

    // Register model
    logic [7:0]  m_gpio;
    logic [7:0]  m_ui;
    logic [4:0]  m_sel  [0:7];
    logic [7:0]  m_bank [0:1][0:3];

    peri_bus_top #(
        .NUM_SIMPLE (2)
    ) peri_bus_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (i_ui_in),
        .i_addr          (i_addr),
        .i_data          (i_data),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .i_read_complete (i_read_complete),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready),
        .o_uo_out        (o_uo_out)
    );

    bind read_return peri_bus_checker u_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_req      (i_read_req),
        .i_read_complete (i_read_complete),
        .i_data_out      (o_data_out),
        .i_read_ready    (o_read_ready),
        .i_data_hold     (data_hold)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic size_n_t rand_size();
        logic [31:0] r;
        r = $random(seed);
        case (r[1:0])
            2'd0:    return SIZE_BYTE;
            2'd1:    return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

    // Mix of mapped registers, unmapped offsets and unmapped slots
    function automatic logic [ADDR_W-1:0] gen_addr();
        logic [31:0] r;
        r = $random(seed);
        case (r[30:28])
            3'd0:       return {1'b0, 4'd1, 6'h00};
            3'd1:       return {1'b0, 4'd1, 6'h04};
            3'd2:       return {1'b0, 4'd1, 1'b1, r[2:0], 2'b00};
            3'd3:       return {1'b0, 4'd1, r[5:0]};
            3'd4, 3'd5: return {1'b1, r[9:8], 3'b000, r[4], 2'b00, r[1:0]};
            3'd6:       return {1'b1, r[9:8], 3'b000, r[4], r[3:0]};
            default:    return r[10:0];
        endcase
    endfunction

    function automatic void model_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        if (addr[10]) begin
            if (addr[7:4] < 4'd2 && addr[3:2] == 2'b00) begin
                m_bank[addr[4]][addr[1:0]] = data[7:0];
            end
        end else if (addr[9:6] == 4'd1) begin
            if (addr[5:0] == 6'h00) begin
                m_gpio = data[7:0];
            end else if (addr[5] && addr[1:0] == 2'b00) begin
                m_sel[addr[4:2]] = data[4:0];
            end
        end
    endfunction

    function automatic logic [31:0] model_read(input logic [ADDR_W-1:0] addr);
        if (addr[10]) begin
            if (addr[7:4] < 4'd2 && addr[3:2] == 2'b00) begin
                return {24'd0, m_bank[addr[4]][addr[1:0]]};
            end
        end else if (addr[9:6] == 4'd1) begin
            if (addr[5:0] == 6'h00) return {24'd0, m_gpio};
            if (addr[5:0] == 6'h04) return {24'd0, m_ui};
            if (addr[5] && addr[1:0] == 2'b00) return {27'd0, m_sel[addr[4:2]]};
        end
        return 32'd0;
    endfunction

    function automatic logic [7:0] model_pins();
        logic [7:0] pins;
        logic [7:0] src;
        logic [4:0] s;
        for (int p = 0; p < 8; p++) begin
            s = m_sel[p];
            if (s[4]) begin
                src = (s[3:0] < 4'd2) ? m_bank[s[0]][0] : 8'h00;
            end else begin
                src = (s[3:0] == 4'd1) ? m_gpio : 8'h00;
            end
            pins[p] = src[p];
        end
        return pins;
    endfunction

    // Called just after a falling edge, returns on the next one
    task automatic bus_write(input string name, input logic [ADDR_W-1:0] addr,
                             input logic [31:0] data);
        i_addr    = addr;
        i_data    = data;
        i_write_n = rand_size();
        #2;
        check_eq({name, " ready"}, 32'd1, {31'd0, o_data_ready});
        model_write(addr, data);
        @(negedge clk);
        i_write_n = SIZE_IDLE;
        check_eq({name, " pins"}, {24'd0, model_pins()}, {24'd0, o_uo_out});
    endtask

    task automatic bus_read(input string name, input logic [ADDR_W-1:0] addr,
                            input logic [31:0] exp, input bit complete);
        i_addr   = addr;
        i_read_n = rand_size();
        @(negedge clk);
        check_eq({name, " ready"}, 32'd1, {31'd0, o_data_ready});
        check_eq(name, exp, o_data_out);
        i_read_n = SIZE_IDLE;
        if (complete) begin
            i_read_complete = 1'b1;
            @(negedge clk);
            i_read_complete = 1'b0;
        end
    endtask

    initial begin
        logic [31:0]       r;
        logic [4:0]        sel;
        logic [ADDR_W-1:0] addr;
        seed            = 32'h8078;
        errors          = 0;
        checks          = 0;
        rst_n           = 1'b0;
        i_ui_in         = 8'h00;
        i_addr          = '0;
        i_data          = '0;
        i_write_n       = SIZE_IDLE;
        i_read_n        = SIZE_IDLE;
        i_read_complete = 1'b0;
        m_gpio          = 8'h00;
        m_ui            = 8'h00;
        for (int p = 0; p < 8; p++) begin
            m_sel[p] = 5'b0_0001;
        end
        for (int b = 0; b < 2; b++) begin
            for (int k = 0; k < 4; k++) begin
                m_bank[b][k] = 8'h00;
            end
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_eq("reset ready idle", 32'd0, {31'd0, o_data_ready});
        check_eq("reset pins", 32'd0, {24'd0, o_uo_out});
        for (int p = 0; p < PIN_COUNT; p++) begin
            addr = {1'b0, 4'd1, 1'b1, 3'(p), 2'b00};
            bus_read("reset pin select", addr, model_read(addr), 1'b1);
        end

        // Second read while held must return the first value
        bus_write("held setup gpio", 11'h040, 32'h0000_005A);
        bus_write("held setup bank", 11'h401, 32'h0000_00C3);
        bus_read("held first", 11'h040, model_read(11'h040), 1'b0);
        bus_read("held second", 11'h401, model_read(11'h040), 1'b1);
        bus_read("after release", 11'h401, model_read(11'h401), 1'b1);

        for (int i = 0; i < NUM_RAND; i++) begin
            r       = $random(seed);
            m_ui    = r[15:8];
            i_ui_in = m_ui;
            addr    = gen_addr();
            if (r[0]) begin
                bus_write("random write", addr, $random(seed));
            end else begin
                bus_read("random read", addr, model_read(addr), 1'b1);
            end
        end

        // Selects biased toward GPIO, bank 0, bank 1 and nearby empty slots
        for (int i = 0; i < NUM_ROUTE; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0: bus_write("route gpio", {1'b0, 4'd1, 6'h00}, $random(seed));
                2'd1: bus_write("route bank", {1'b1, 2'b00, 3'b000, r[2], 4'd0}, $random(seed));
                default: begin
                    sel = r[8] ? {r[3], 2'b00, r[5:4]} : r[7:3];
                    bus_write("route select", {1'b0, 4'd1, 1'b1, r[11:9], 2'b00}, {27'd0, sel});
                end
            endcase
        end

        assert_fails = peri_bus_top_i.u_read_return.u_checker.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (NUM_OPS * 4 + 100) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", NUM_OPS * 4 + 100);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- sim.f
hdl/peri_bus_pkg.sv
hdl/peri_map_pkg.sv
hdl/peri_addr_decode.sv
hdl/read_return.sv
hdl/gpio_regs.sv
hdl/pin_func_mux.sv
hdl/byte_reg_bank.sv
hdl/peri_bus_top.sv
sim/peri_bus_checker.sv
sim/tb_peri_bus.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the peripheral bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_peri_bus -f sim.f

status=0
out=$(./obj_dir/Vtb_peri_bus) || status=$?
printf '%s\n' "$out"
[ "$status" -eq 0 ]
printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"
